// File: hdl/hid_ctrl.sv
/*
 * Host bus controller
 * Region decode, SD register file and readback, status capture,
 * card detect interrupt and LED register
 */
`timescale 1ns/10ps

module hid_ctrl
   import periph_pkg::*;
(
   input  logic           msoc_clk,
   input  logic           rstn,
   input  logic           hid_en_i,
   input  hid_we_t        hid_we_i,
   input  hid_addr_t      hid_addr_i,
   input  hid_data_t      hid_wrdata_i,
   output hid_data_t      hid_rddata_o,
   output sd_cmd_req_t    sd_cmd_req_o,
   output sd_rst_t        sd_rst_o,
   input  sd_core_stat_t  sd_core_stat_i,
   input  logic           sd_detect_i,
   input  logic [15:0]    from_dip_i,
   output logic           sd_irq_o,
   output logic [7:0]     to_led_o,
   output logic           kbd_pop_o,
   input  kbd_code_t      kbd_head_i,
   input  logic           kbd_empty_i,
   output logic           buf_en_o,
   output logic           buf_we_o,
   output buf_addr_t      buf_addr_o,
   output hid_data_t      buf_wdata_o,
   input  hid_data_t      buf_rdata_i
);

   region_t       acc_region;
   reg_idx_t      acc_idx;
   logic          wr_acc;
   logic          rd_acc;
   logic          reg_wr;

   region_t       region_q;                 // Region of the last read
   logic          rd_vld_q;
   hid_data_t     rb_sel;
   hid_data_t     rb_q;
   hid_data_t     kbd_word_q;
   hid_data_t     rd_word;

   sd_cmd_req_t   cmd_req_q;
   sd_rst_t       sd_rst_q;
   logic [3:0]    irq_en_q;
   logic [7:0]    led_q;

   sd_core_stat_t stat_q;
   logic          detect_q;
   logic [15:0]   dip_q;
   logic [3:0]    irq_stat_q;
   logic          irq_q;

   assign acc_region = hid_addr_i[16:15];
   assign acc_idx    = hid_addr_i[6:2];
   assign wr_acc     = hid_en_i & (|hid_we_i);
   assign rd_acc     = hid_en_i & ~(|hid_we_i);
   assign reg_wr     = wr_acc & (acc_region == REGION_SDREG) & ~hid_addr_i[14];

   // Any write to the keyboard region pops the head entry
   assign kbd_pop_o   = wr_acc & (acc_region == REGION_KEYB);

   assign buf_en_o    = hid_en_i & (acc_region == REGION_SDBUF);
   assign buf_we_o    = |hid_we_i;
   assign buf_addr_o  = hid_addr_i[10:2];
   assign buf_wdata_o = hid_wrdata_i;

   // SD register file
   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         cmd_req_q <= '0;
         sd_rst_q  <= '0;
         irq_en_q  <= '0;
         led_q     <= '0;
      end
      else if (reg_wr)
      begin
         case (acc_idx)
            REG_ALIGN:   cmd_req_q.align     <= hid_wrdata_i[1:0];
            REG_ARG:     cmd_req_q.arg       <= hid_wrdata_i;
            REG_CMD:     cmd_req_q.cmd_index <= hid_wrdata_i[5:0];
            REG_SETTING: {cmd_req_q.data_start, cmd_req_q.setting} <= hid_wrdata_i[5:0];
            REG_START:   cmd_req_q.start     <= hid_wrdata_i[0];
            REG_RESET:   sd_rst_q            <= hid_wrdata_i[3:0];
            REG_BLKCNT:  cmd_req_q.blkcnt    <= hid_wrdata_i[15:0];
            REG_BLKSIZE: cmd_req_q.blksize   <= hid_wrdata_i[11:0];
            REG_TIMEOUT: cmd_req_q.timeout   <= hid_wrdata_i;
            REG_IRQ_EN:  irq_en_q            <= hid_wrdata_i[3:0];
            REG_LED:     led_q               <= hid_wrdata_i[7:0];
            default: ;
         endcase
      end
   end

   assign sd_cmd_req_o = cmd_req_q;
   assign sd_rst_o     = sd_rst_q;
   assign to_led_o     = led_q;

   // Engine status, low nibble of status is reserved
   always_ff @(posedge msoc_clk)
   begin
      stat_q              <= sd_core_stat_i;
      stat_q.status[3:0]  <= 4'b0;
   end

   // Detect and DIP sampling, interrupt pipeline
   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         detect_q   <= 1'b0;
         dip_q      <= '0;
         irq_stat_q <= '0;
         irq_q      <= 1'b0;
      end
      else
      begin
         detect_q   <= sd_detect_i;
         dip_q      <= from_dip_i;
         irq_stat_q <= {~detect_q, detect_q, stat_q.status[10], stat_q.status[8]};
         irq_q      <= |(irq_en_q & irq_stat_q);
      end
   end

   assign sd_irq_o = irq_q;

   // Register readback select
   always_comb
   begin
      case (acc_idx)
         RB_RESP0:               rb_sel = stat_q.response[0];
         RB_RESP1:               rb_sel = stat_q.response[1];
         RB_RESP2:               rb_sel = stat_q.response[2];
         RB_RESP3:               rb_sel = stat_q.response[3];
         RB_CMD_WAIT:            rb_sel = stat_q.cmd_wait;
         RB_STATUS:              rb_sel = stat_q.status;
         RB_DATA_WAIT:           rb_sel = stat_q.data_wait;
         RB_TRANSF:              rb_sel = hid_data_t'(stat_q.transf_cnt);
         RB_DETECT:              rb_sel = hid_data_t'(detect_q);
         RB_XFR_ADDR:            rb_sel = hid_data_t'(stat_q.xfr_addr);
         RB_IRQ_STAT:            rb_sel = hid_data_t'(irq_stat_q);
         RB_ECHO + REG_ALIGN:    rb_sel = hid_data_t'(cmd_req_q.align);
         RB_ECHO + REG_ARG:      rb_sel = cmd_req_q.arg;
         RB_ECHO + REG_CMD:      rb_sel = hid_data_t'(cmd_req_q.cmd_index);
         RB_ECHO + REG_SETTING:  rb_sel = hid_data_t'({cmd_req_q.data_start,
                                                        cmd_req_q.setting});
         RB_ECHO + REG_START:    rb_sel = hid_data_t'(cmd_req_q.start);
         RB_ECHO + REG_RESET:    rb_sel = hid_data_t'(sd_rst_q);
         RB_ECHO + REG_BLKCNT:   rb_sel = hid_data_t'(cmd_req_q.blkcnt);
         RB_ECHO + REG_BLKSIZE:  rb_sel = hid_data_t'(cmd_req_q.blksize);
         RB_ECHO + REG_TIMEOUT:  rb_sel = cmd_req_q.timeout;
         RB_ECHO + REG_IRQ_EN:   rb_sel = hid_data_t'(irq_en_q);
         RB_DIP:                 rb_sel = hid_data_t'(dip_q);   // Boot mode switches
         default:                rb_sel = UNMAPPED_WORD;
      endcase
   end

   // Read data sampled in the access cycle
   always_ff @(posedge msoc_clk)
   begin
      rb_q       <= rb_sel;
      kbd_word_q <= {15'b0, kbd_empty_i, 1'b0, kbd_head_i};
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         region_q <= REGION_KEYB;
         rd_vld_q <= 1'b0;
      end
      else
      begin
         rd_vld_q <= rd_acc;
         if (rd_acc)
            region_q <= acc_region;
      end
   end

   always_comb
   begin
      case (region_q)
         REGION_KEYB:  rd_word = kbd_word_q;
         REGION_SDREG: rd_word = rb_q;
         REGION_SDBUF: rd_word = buf_rdata_i;
         default:      rd_word = '0;        // Video region is gone
      endcase
   end

   assign hid_rddata_o = rd_vld_q ? rd_word : '0;

endmodule

// File: hdl/keyb_fifo.sv
/*
 * Keyboard code FIFO
 * Circular buffer, each pop hands one credit back to the producer
 */
`timescale 1ns/10ps

module keyb_fifo
   import periph_pkg::*;
#(
   parameter int DEPTH = KEYB_DEPTH_DEF
)
(
   input  logic      msoc_clk,
   input  logic      rstn,
   input  logic      push_i,
   input  kbd_code_t push_data_i,
   input  logic      pop_i,
   output kbd_code_t head_o,
   output logic      empty_o,
   output logic      credit_o
);

   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   kbd_code_t       mem [DEPTH];
   logic [PW-1:0]   wr_ptr;
   logic [PW-1:0]   rd_ptr;
   logic [CW-1:0]   count;
   logic            do_push;
   logic            do_pop;

   assign do_push = push_i & (count != CW'(DEPTH));   // Push into a full FIFO is lost
   assign do_pop  = pop_i & (count != '0);

   always_ff @(posedge msoc_clk)
   begin
      if (do_push)
         mem[wr_ptr] <= push_data_i;
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         credit_o <= 1'b0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         count    <= count + CW'(do_push) - CW'(do_pop);
         credit_o <= do_pop;                  // One credit per real pop
      end
   end

   assign head_o  = mem[rd_ptr];
   assign empty_o = (count == '0);

endmodule

// File: hdl/periph_pkg.sv
/*
 * Peripheral hub package
 * Bus types, SD engine request and status records, region and register maps
 */
package periph_pkg;

   // Host bus
   typedef logic [16:0] hid_addr_t;       // Byte address
   typedef logic [31:0] hid_data_t;       // Data word
   typedef logic [3:0]  hid_we_t;         // Byte write strobes

   typedef logic [1:0]  region_t;         // Address bits 16:15
   typedef logic [4:0]  reg_idx_t;        // Word address bits 6:2
   typedef logic [8:0]  buf_addr_t;       // Transfer buffer word address

   // ASCII code above scan code
   typedef logic [14:0] kbd_code_t;

   // Command and transfer settings towards the SD engine
   typedef struct packed {
      logic [2:0]  setting;
      logic [2:0]  data_start;
      logic [5:0]  cmd_index;
      logic [31:0] arg;
      logic [31:0] timeout;
      logic        start;
      logic [1:0]  align;
      logic [15:0] blkcnt;
      logic [11:0] blksize;
   } sd_cmd_req_t;

   typedef struct packed {
      logic card_reset;
      logic clk_rst;
      logic data_rst;
      logic cmd_rst;
   } sd_rst_t;

   // Status returned by the SD engine
   typedef struct packed {
      hid_data_t [3:0] response;          // Word 0 in the low bits
      hid_data_t       cmd_wait;
      hid_data_t       data_wait;
      hid_data_t       status;
      logic [15:0]     transf_cnt;
      buf_addr_t       xfr_addr;
      logic            finish_cmd;
      logic            finish_data;
   } sd_core_stat_t;

   localparam region_t REGION_KEYB  = 2'd0;
   localparam region_t REGION_VIDEO = 2'd1;
   localparam region_t REGION_SDREG = 2'd2;
   localparam region_t REGION_SDBUF = 2'd3;

   // Write side of the SD register block
   localparam reg_idx_t REG_ALIGN   = 5'd0;
   localparam reg_idx_t REG_ARG     = 5'd2;
   localparam reg_idx_t REG_CMD     = 5'd3;
   localparam reg_idx_t REG_SETTING = 5'd4;
   localparam reg_idx_t REG_START   = 5'd5;
   localparam reg_idx_t REG_RESET   = 5'd6;
   localparam reg_idx_t REG_BLKCNT  = 5'd7;
   localparam reg_idx_t REG_BLKSIZE = 5'd8;
   localparam reg_idx_t REG_TIMEOUT = 5'd9;
   localparam reg_idx_t REG_IRQ_EN  = 5'd11;
   localparam reg_idx_t REG_LED     = 5'd15;

   // Readback side
   localparam reg_idx_t RB_RESP0     = 5'd0;
   localparam reg_idx_t RB_RESP1     = 5'd1;
   localparam reg_idx_t RB_RESP2     = 5'd2;
   localparam reg_idx_t RB_RESP3     = 5'd3;
   localparam reg_idx_t RB_CMD_WAIT  = 5'd4;
   localparam reg_idx_t RB_STATUS    = 5'd5;
   localparam reg_idx_t RB_DATA_WAIT = 5'd8;
   localparam reg_idx_t RB_TRANSF    = 5'd9;
   localparam reg_idx_t RB_DETECT    = 5'd12;
   localparam reg_idx_t RB_XFR_ADDR  = 5'd13;
   localparam reg_idx_t RB_IRQ_STAT  = 5'd14;
   localparam reg_idx_t RB_ECHO      = 5'd16;   // Write register N reads at N + 16
   localparam reg_idx_t RB_DIP       = 5'd31;

   localparam hid_data_t UNMAPPED_WORD = 32'hDEADBEEF;

   localparam int KEYB_DEPTH_DEF = 16;
   localparam int BUF_WORDS      = 512;      // One word per buffer address

endpackage

// File: hdl/periph_soc.sv
/*
 * Peripheral hub top
 * Host bus decode and SD registers, keyboard FIFO and SD transfer buffer
 */
`timescale 1ns/10ps

module periph_soc
   import periph_pkg::*;
#(
   parameter int KEYB_DEPTH = KEYB_DEPTH_DEF
)
(
   input  logic           msoc_clk,
   input  logic           rstn,
   // Host bus
   input  logic           hid_en_i,
   input  hid_we_t        hid_we_i,
   input  hid_addr_t      hid_addr_i,
   input  hid_data_t      hid_wrdata_i,
   output hid_data_t      hid_rddata_o,
   // SD engine
   output sd_cmd_req_t    sd_cmd_req_o,
   output sd_rst_t        sd_rst_o,
   input  sd_core_stat_t  sd_core_stat_i,
   input  logic           sd_buf_rd_i,
   input  logic           sd_buf_we_i,
   input  buf_addr_t      sd_buf_addr_i,
   input  hid_data_t      sd_buf_wdata_i,
   output hid_data_t      sd_buf_rdata_o,
   // Keyboard source
   input  logic           kbd_valid_i,
   input  kbd_code_t      kbd_code_i,
   output logic           kbd_credit_o,
   // Pins
   input  logic           sd_detect_i,
   output logic           sd_irq_o,
   input  logic [15:0]    from_dip_i,
   output logic [7:0]     to_led_o
);

   logic      kbd_pop;
   kbd_code_t kbd_head;
   logic      kbd_empty;
   logic      buf_en;
   logic      buf_we;
   buf_addr_t buf_addr;
   hid_data_t buf_wdata;
   hid_data_t buf_rdata;

   hid_ctrl u_hid_ctrl (
      .msoc_clk       (msoc_clk),
      .rstn           (rstn),
      .hid_en_i       (hid_en_i),
      .hid_we_i       (hid_we_i),
      .hid_addr_i     (hid_addr_i),
      .hid_wrdata_i   (hid_wrdata_i),
      .hid_rddata_o   (hid_rddata_o),
      .sd_cmd_req_o   (sd_cmd_req_o),
      .sd_rst_o       (sd_rst_o),
      .sd_core_stat_i (sd_core_stat_i),
      .sd_detect_i    (sd_detect_i),
      .from_dip_i     (from_dip_i),
      .sd_irq_o       (sd_irq_o),
      .to_led_o       (to_led_o),
      .kbd_pop_o      (kbd_pop),
      .kbd_head_i     (kbd_head),
      .kbd_empty_i    (kbd_empty),
      .buf_en_o       (buf_en),
      .buf_we_o       (buf_we),
      .buf_addr_o     (buf_addr),
      .buf_wdata_o    (buf_wdata),
      .buf_rdata_i    (buf_rdata)
   );

   keyb_fifo #(.DEPTH(KEYB_DEPTH)) u_keyb_fifo (
      .msoc_clk    (msoc_clk),
      .rstn        (rstn),
      .push_i      (kbd_valid_i),
      .push_data_i (kbd_code_i),
      .pop_i       (kbd_pop),
      .head_o      (kbd_head),
      .empty_o     (kbd_empty),
      .credit_o    (kbd_credit_o)
   );

   // Side A belongs to the SD engine, side B to the host
   sd_xfr_buffer #(.WORDS(BUF_WORDS)) u_sd_xfr_buffer (
      .msoc_clk  (msoc_clk),
      .a_en_i    (sd_buf_rd_i | sd_buf_we_i),
      .a_we_i    (sd_buf_we_i),
      .a_addr_i  (sd_buf_addr_i),
      .a_wdata_i (sd_buf_wdata_i),
      .a_rdata_o (sd_buf_rdata_o),
      .b_en_i    (buf_en),
      .b_we_i    (buf_we),
      .b_addr_i  (buf_addr),
      .b_wdata_i (buf_wdata),
      .b_rdata_o (buf_rdata)
   );

endmodule

// File: hdl/sd_xfr_buffer.sv
/*
 * SD transfer buffer
 * True dual-port RAM, read-before-write on each side
 */
`timescale 1ns/10ps

module sd_xfr_buffer
   import periph_pkg::*;
#(
   parameter int WORDS = BUF_WORDS
)
(
   input  logic      msoc_clk,
   // Side A, SD engine
   input  logic      a_en_i,
   input  logic      a_we_i,
   input  buf_addr_t a_addr_i,
   input  hid_data_t a_wdata_i,
   output hid_data_t a_rdata_o,
   // Side B, host bus
   input  logic      b_en_i,
   input  logic      b_we_i,
   input  buf_addr_t b_addr_i,
   input  hid_data_t b_wdata_i,
   output hid_data_t b_rdata_o
);

   hid_data_t mem [WORDS];

   // Old contents come out when a side writes
   always @(posedge msoc_clk)
   begin
      if (a_en_i)
      begin
         a_rdata_o <= mem[a_addr_i];
         if (a_we_i)
            mem[a_addr_i] <= a_wdata_i;
      end
   end

   always @(posedge msoc_clk)
   begin
      if (b_en_i)
      begin
         b_rdata_o <= mem[b_addr_i];
         if (b_we_i)
            mem[b_addr_i] <= b_wdata_i;     // Same word from both sides is undefined
      end
   end

endmodule

// File: tb.f
+incdir+tb
hdl/periph_pkg.sv
hdl/sd_xfr_buffer.sv
hdl/keyb_fifo.sv
hdl/hid_ctrl.sv
hdl/periph_soc.sv
tb/tb_clkgen.sv
tb/periph_soc_tb.sv

// File: tb/hid_bus_tasks.svh
/*
 * Host bus and keyboard source tasks
 * Each task starts and ends on a falling clock edge
 */
`ifndef HID_BUS_TASKS_SVH
`define HID_BUS_TASKS_SVH

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge msoc_clk);
   endtask

   // Full word write, lands on the next rising edge
   task automatic bus_write(input hid_addr_t addr, input hid_data_t data);
      hid_en     = 1'b1;
      hid_we     = 4'hf;
      hid_addr   = addr;
      hid_wrdata = data;
      @(negedge msoc_clk);
      hid_en     = 1'b0;
      hid_we     = 4'h0;
   endtask

   // Read word is on the bus one cycle after the access
   task automatic bus_read(input hid_addr_t addr, output hid_data_t data);
      hid_en   = 1'b1;
      hid_we   = 4'h0;
      hid_addr = addr;
      @(negedge msoc_clk);
      hid_en   = 1'b0;
      data     = hid_rddata;
   endtask

   // Keyboard producer, pushes only while it holds a credit
   task automatic kbd_push(input kbd_code_t code);
      if (credits_used - credits_back < KEYB_DEPTH)
      begin
         kbd_valid = 1'b1;
         kbd_code  = code;
         credits_used++;
         codes.push_back(code);
      end
      @(negedge msoc_clk);
      kbd_valid = 1'b0;
   endtask

`endif

// File: tb/periph_soc_tb.sv
/*
 * Peripheral hub testbench
 * Register file, keyboard FIFO with credits, transfer buffer, status and interrupt
 */
`timescale 1ns/10ps

module periph_soc_tb;
   import periph_pkg::*;

   localparam int PERIOD     = 8;
   localparam int KEYB_DEPTH = KEYB_DEPTH_DEF;
   localparam int NBUF       = 8;
   localparam int BUS_OPS    = 140;                        // Bus and SD port operations
   localparam int TIMEOUT_NS = (BUS_OPS * 10 + 100) * PERIOD;

   logic          msoc_clk;
   logic          rstn;
   logic          hid_en;
   hid_we_t       hid_we;
   hid_addr_t     hid_addr;
   hid_data_t     hid_wrdata;
   hid_data_t     hid_rddata;
   sd_cmd_req_t   sd_cmd_req;
   sd_rst_t       sd_rst;
   sd_core_stat_t sd_stat;
   logic          sd_buf_rd;
   logic          sd_buf_we;
   buf_addr_t     sd_buf_addr;
   hid_data_t     sd_buf_wdata;
   hid_data_t     sd_buf_rdata;
   logic          kbd_valid;
   kbd_code_t     kbd_code;
   logic          kbd_credit;
   logic          sd_detect;
   logic          sd_irq;
   logic [15:0]   dip;
   logic [7:0]    led;

   integer        seed;
   int            errors;
   int            checks;
   int            credits_used;
   int            credits_back;
   hid_data_t     rdata;
   hid_data_t     wval;
   hid_data_t     arg_saved;
   buf_addr_t     ba;
   reg_idx_t      wr_idx [11];
   kbd_code_t     codes [$];

   tb_clkgen #(.PERIOD(PERIOD), .RST_CYCLES(3)) u_clkgen (
      .clk_o  (msoc_clk),
      .rstn_o (rstn)
   );

   periph_soc #(.KEYB_DEPTH(KEYB_DEPTH)) dut (
      .msoc_clk       (msoc_clk),
      .rstn           (rstn),
      .hid_en_i       (hid_en),
      .hid_we_i       (hid_we),
      .hid_addr_i     (hid_addr),
      .hid_wrdata_i   (hid_wrdata),
      .hid_rddata_o   (hid_rddata),
      .sd_cmd_req_o   (sd_cmd_req),
      .sd_rst_o       (sd_rst),
      .sd_core_stat_i (sd_stat),
      .sd_buf_rd_i    (sd_buf_rd),
      .sd_buf_we_i    (sd_buf_we),
      .sd_buf_addr_i  (sd_buf_addr),
      .sd_buf_wdata_i (sd_buf_wdata),
      .sd_buf_rdata_o (sd_buf_rdata),
      .kbd_valid_i    (kbd_valid),
      .kbd_code_i     (kbd_code),
      .kbd_credit_o   (kbd_credit),
      .sd_detect_i    (sd_detect),
      .sd_irq_o       (sd_irq),
      .from_dip_i     (dip),
      .to_led_o       (led)
   );

   `include "hid_bus_tasks.svh"

   function automatic hid_addr_t reg_addr(input region_t region, input reg_idx_t idx);
      return {region, 8'b0, idx, 2'b00};
   endfunction

   function automatic hid_addr_t buf_word(input buf_addr_t a);
      return {REGION_SDBUF, 4'b0, a, 2'b00};
   endfunction

   // Implemented width of each write register
   function automatic hid_data_t field_mask(input reg_idx_t idx);
      case (idx)
         REG_ALIGN:              return 32'h3;
         REG_CMD, REG_SETTING:   return 32'h3f;
         REG_START:              return 32'h1;
         REG_RESET, REG_IRQ_EN:  return 32'hf;
         REG_BLKCNT:             return 32'hffff;
         REG_BLKSIZE:            return 32'hfff;
         REG_LED:                return 32'hff;
         default:                return 32'hffffffff;
      endcase
   endfunction

   // Output pins that carry each write register
   function automatic hid_data_t field_out(input reg_idx_t idx);
      case (idx)
         REG_ALIGN:   return hid_data_t'(sd_cmd_req.align);
         REG_ARG:     return sd_cmd_req.arg;
         REG_CMD:     return hid_data_t'(sd_cmd_req.cmd_index);
         REG_SETTING: return hid_data_t'({sd_cmd_req.data_start, sd_cmd_req.setting});
         REG_START:   return hid_data_t'(sd_cmd_req.start);
         REG_RESET:   return hid_data_t'(sd_rst);
         REG_BLKCNT:  return hid_data_t'(sd_cmd_req.blkcnt);
         REG_BLKSIZE: return hid_data_t'(sd_cmd_req.blksize);
         REG_TIMEOUT: return sd_cmd_req.timeout;
         REG_LED:     return hid_data_t'(led);
         default:     return 32'h0;
      endcase
   endfunction

   task automatic check_word(input hid_data_t got, input hid_data_t exp, input string what);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   // One buffer port access by the SD engine model
   task automatic sd_access(input logic we, input buf_addr_t a, input hid_data_t d);
      sd_buf_rd    = ~we;
      sd_buf_we    = we;
      sd_buf_addr  = a;
      sd_buf_wdata = d;
      @(negedge msoc_clk);
      sd_buf_rd    = 1'b0;
      sd_buf_we    = 1'b0;
   endtask

   // Read data bus is zero in every cycle that follows no read
   assert property (@(posedge msoc_clk) disable iff (!rstn)
                    !(hid_en && !(|hid_we)) |=> hid_rddata == '0)
   else
   begin
      errors++;
      $display("mismatch at %0t: read data not zero between reads", $time);
   end

   // Producer collects returned credits
   always @(negedge msoc_clk)
   begin
      if (rstn && kbd_credit)
         credits_back++;
   end

   initial
   begin
      #(TIMEOUT_NS);
      $display("Watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
      $display("Summary: %0d checks, %0d errors", checks, errors);
      $display("Test failed");
      $finish;
   end

   initial
   begin
      seed = 32'h738c6edf;
      errors = 0;
      checks = 0;
      credits_used = 0;
      credits_back = 0;
      hid_en = 1'b0;
      hid_we = '0;
      hid_addr = '0;
      hid_wrdata = '0;
      sd_stat = '0;
      sd_buf_rd = 1'b0;
      sd_buf_we = 1'b0;
      sd_buf_addr = '0;
      sd_buf_wdata = '0;
      kbd_valid = 1'b0;
      kbd_code = '0;
      sd_detect = 1'b0;
      dip = 16'($random(seed));
      wr_idx = '{REG_ALIGN, REG_ARG, REG_CMD, REG_SETTING, REG_START, REG_RESET,
                 REG_BLKCNT, REG_BLKSIZE, REG_TIMEOUT, REG_IRQ_EN, REG_LED};
      wait (rstn === 1'b1);
      @(negedge msoc_clk);
      check_word(hid_data_t'({sd_irq, kbd_credit, led, sd_rst}), 32'h0, "pins after reset");
      check_word(hid_data_t'(|sd_cmd_req), 32'h0, "command request after reset");

      // Register round trip
      foreach (wr_idx[i])
      begin
         wval = $random(seed);
         bus_write(reg_addr(REGION_SDREG, wr_idx[i]), wval);
         if (wr_idx[i] != REG_IRQ_EN)
            check_word(field_out(wr_idx[i]), wval & field_mask(wr_idx[i]), "register output");
         if (wr_idx[i] != REG_LED)
         begin
            bus_read(reg_addr(REGION_SDREG, wr_idx[i] + 5'd16), rdata);
            check_word(rdata, wval & field_mask(wr_idx[i]), "register echo");
         end
      end
      bus_read(reg_addr(REGION_SDREG, RB_DIP), rdata);
      check_word(rdata, hid_data_t'(dip), "DIP switches");
      bus_read(reg_addr(REGION_SDREG, 5'd10), rdata);
      check_word(rdata, UNMAPPED_WORD, "unmapped index");

      // Video region is gone
      arg_saved = sd_cmd_req.arg;
      bus_write(reg_addr(REGION_VIDEO, REG_ARG), ~arg_saved);
      bus_read(reg_addr(REGION_SDREG, REG_ARG + 5'd16), rdata);
      check_word(rdata, arg_saved, "argument after video write");
      bus_read(reg_addr(REGION_VIDEO, REG_ARG), rdata);
      check_word(rdata, 32'h0, "video region read");

      // Keyboard FIFO and credits
      while (codes.size() < KEYB_DEPTH)
         kbd_push(kbd_code_t'($random(seed)));
      for (int i = 0; i < KEYB_DEPTH; i++)
      begin
         bus_read(reg_addr(REGION_KEYB, 5'd0), rdata);
         check_word(rdata, hid_data_t'(codes[i]), "keyboard head");
         bus_write(reg_addr(REGION_KEYB, 5'd0), 32'h0);
         check_word(hid_data_t'(kbd_credit), 32'h1, "credit after pop");
      end
      bus_read(reg_addr(REGION_KEYB, 5'd0), rdata);
      check_word(rdata & 32'h0001_0000, 32'h0001_0000, "empty flag");
      check_word(KEYB_DEPTH - credits_used + credits_back, KEYB_DEPTH, "producer credits");

      // Transfer buffer in both directions
      for (int i = 0; i < NBUF; i++)
      begin
         ba = buf_addr_t'(i * 67 + 5);
         wval = $random(seed);
         bus_write(buf_word(ba), wval);
         sd_access(1'b0, ba, 32'h0);
         check_word(sd_buf_rdata, wval, "SD read of host word");
         wval = $random(seed);
         sd_access(1'b1, ba + 9'd1, wval);
         bus_read(buf_word(ba + 9'd1), rdata);
         check_word(rdata, wval, "host read of SD word");
      end

      // Status readback
      sd_stat.response = {$random(seed), $random(seed), $random(seed), $random(seed)};
      sd_stat.cmd_wait = $random(seed);
      sd_stat.data_wait = $random(seed);
      sd_stat.status = $random(seed);
      sd_stat.transf_cnt = 16'($random(seed));
      sd_stat.xfr_addr = buf_addr_t'($random(seed));
      wait_cycles(1);
      for (int k = 0; k < 4; k++)
      begin
         bus_read(reg_addr(REGION_SDREG, reg_idx_t'(k)), rdata);
         check_word(rdata, sd_stat.response[k], "response word");
      end
      bus_read(reg_addr(REGION_SDREG, RB_CMD_WAIT), rdata);
      check_word(rdata, sd_stat.cmd_wait, "command wait");
      bus_read(reg_addr(REGION_SDREG, RB_STATUS), rdata);
      check_word(rdata, sd_stat.status & ~32'hf, "status");
      bus_read(reg_addr(REGION_SDREG, RB_DATA_WAIT), rdata);
      check_word(rdata, sd_stat.data_wait, "data wait");
      bus_read(reg_addr(REGION_SDREG, RB_TRANSF), rdata);
      check_word(rdata, hid_data_t'(sd_stat.transf_cnt), "transfer count");
      bus_read(reg_addr(REGION_SDREG, RB_XFR_ADDR), rdata);
      check_word(rdata, hid_data_t'(sd_stat.xfr_addr), "transfer address");

      // Interrupt with only the detect enable set
      sd_stat = '0;
      bus_write(reg_addr(REGION_SDREG, REG_IRQ_EN), 32'h4);
      wait_cycles(3);
      check_word(hid_data_t'(sd_irq), 32'h0, "irq before detect");
      sd_detect = 1'b1;
      for (int k = 1; k <= 3; k++)
      begin
         @(negedge msoc_clk);
         check_word(hid_data_t'(sd_irq), hid_data_t'(k == 3), "irq latency");
      end
      sd_stat.status[10] = 1'b1;
      wait_cycles(2);
      bus_read(reg_addr(REGION_SDREG, RB_IRQ_STAT), rdata);
      check_word(rdata, 32'h6, "interrupt status");        // Detect and status bit 10
      bus_read(reg_addr(REGION_SDREG, RB_DETECT), rdata);
      check_word(rdata, 32'h1, "card detect");
      bus_write(reg_addr(REGION_SDREG, REG_IRQ_EN), 32'h0);
      sd_stat.status = 32'hffff_ffff;
      sd_detect = 1'b0;
      wait_cycles(1);
      for (int k = 0; k < 6; k++)
      begin
         @(negedge msoc_clk);
         check_word(hid_data_t'(sd_irq), 32'h0, "irq with enables cleared");
      end

      wait_cycles(2);
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: tb/tb_clkgen.sv
/*
 * Testbench clock and reset generator
 */
`timescale 1ns/10ps

module tb_clkgen
#(
   parameter int PERIOD     = 8,
   parameter int RST_CYCLES = 3
)
(
   output logic clk_o,
   output logic rstn_o
);

   initial
   begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

   initial
   begin
      rstn_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rstn_o = 1'b1;                      // Released away from the rising edge
   end

endmodule
